// File: logic/axi4l_pkg.sv
// AXI4-Lite package with bus widths, response codes and register map constants
`default_nettype none

package axi4l_pkg;

    // Bus widths
    localparam int ADDR_WID      = 12;
    localparam int DATA_BYTE_WID = 4;
    localparam int DATA_WID      = DATA_BYTE_WID * 8;
    localparam int STRB_WID      = DATA_BYTE_WID;

    // Width of the word index above the two low address bits
    localparam int WORD_IDX_WID = ADDR_WID - 2;

    // Response codes without EXOKAY
    typedef enum logic [1:0] {
        RESP_OKAY   = 2'b00,
        RESP_SLVERR = 2'b10,
        RESP_DECERR = 2'b11
    } resp_t;

    // Register map
    localparam int NUM_REGS     = 16;
    localparam int REG_SEL_WID  = $clog2(NUM_REGS);
    localparam int ID_REG_INDEX = 15;

    // Identification word that reads as "REG1"
    localparam logic [DATA_WID-1:0] ID_VALUE = 32'h5245_4731;

endpackage : axi4l_pkg

`default_nettype wire

// File: logic/reg_bus_pkg.sv
// Internal bus package with the payload structs carried on the generic valid/ready buses
`default_nettype none

package reg_bus_pkg;

    // Write or read address payload
    typedef struct packed {
        logic [2:0]                     prot;
        logic [axi4l_pkg::ADDR_WID-1:0] addr;
    } ax_payload_t;

    // Write data payload
    typedef struct packed {
        logic [axi4l_pkg::DATA_WID-1:0] data;
        logic [axi4l_pkg::STRB_WID-1:0] strb;
    } w_payload_t;

    // Write response payload
    typedef struct packed {
        axi4l_pkg::resp_t resp;
    } b_payload_t;

    // Read data payload
    typedef struct packed {
        logic [axi4l_pkg::DATA_WID-1:0] data;
        axi4l_pkg::resp_t               resp;
    } r_payload_t;

endpackage : reg_bus_pkg

`default_nettype wire

// File: logic/bus_fifo.sv
// Valid/ready FIFO with a generic payload type, used on every internal bus
`timescale 1ns/1ps
`default_nettype none

module bus_fifo #(
    parameter type payload_t = logic [7:0],
    parameter int  DEPTH     = 2
) (
    input  logic     aclk,
    input  logic     reset,

    // Producer side
    input  logic     in_valid,
    output logic     in_ready,
    input  payload_t in_data,

    // Consumer side
    output logic     out_valid,
    input  logic     out_ready,
    output payload_t out_data
);

    localparam int PTR_WID = $clog2(DEPTH);
    localparam int CNT_WID = $clog2(DEPTH + 1);

    payload_t           mem [DEPTH];
    logic [PTR_WID-1:0] wr_ptr;
    logic [PTR_WID-1:0] rd_ptr;
    logic [CNT_WID-1:0] count;

    logic push;
    logic pop;

    assign in_ready  = (count != CNT_WID'(DEPTH));
    assign out_valid = (count != '0);
    assign out_data  = mem[rd_ptr];

    assign push = in_valid && in_ready;
    assign pop  = out_valid && out_ready;

    // Payload storage
    always_ff @(posedge aclk) begin
        if (push) begin
            mem[wr_ptr] <= in_data;
        end
    end

    // Pointers wrap naturally since DEPTH is a power of two
    always_ff @(posedge aclk) begin
        if (reset) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            if (push && !pop) begin
                count <= count + 1'b1;
            end else if (pop && !push) begin
                count <= count - 1'b1;
            end
        end
    end

    // Head entry holds until the consumer takes it
    a_out_stable: assert property (
        @(posedge aclk) disable iff (reset)
        out_valid && !out_ready |=> out_valid && $stable(out_data)
    );

    a_count_bound: assert property (
        @(posedge aclk) disable iff (reset)
        count <= CNT_WID'(DEPTH)
    );

endmodule : bus_fifo

`default_nettype wire

// File: logic/axi4l_to_bus_adapter.sv
// AXI4-Lite to generic bus adapter, packs each channel into a payload and buffers it
`timescale 1ns/1ps
`default_nettype none

module axi4l_to_bus_adapter (
    input  logic                           aclk,
    input  logic                           reset,

    // AXI4-Lite subordinate port
    input  logic                           awvalid,
    output logic                           awready,
    input  logic [axi4l_pkg::ADDR_WID-1:0] awaddr,
    input  logic [2:0]                     awprot,
    input  logic                           wvalid,
    output logic                           wready,
    input  logic [axi4l_pkg::DATA_WID-1:0] wdata,
    input  logic [axi4l_pkg::STRB_WID-1:0] wstrb,
    output logic                           bvalid,
    input  logic                           bready,
    output axi4l_pkg::resp_t               bresp,
    input  logic                           arvalid,
    output logic                           arready,
    input  logic [axi4l_pkg::ADDR_WID-1:0] araddr,
    input  logic [2:0]                     arprot,
    output logic                           rvalid,
    input  logic                           rready,
    output logic [axi4l_pkg::DATA_WID-1:0] rdata,
    output axi4l_pkg::resp_t               rresp,

    // Request buses toward the register bank
    output logic                           aw_valid,
    input  logic                           aw_ready,
    output reg_bus_pkg::ax_payload_t       aw_data,
    output logic                           w_valid,
    input  logic                           w_ready,
    output reg_bus_pkg::w_payload_t        w_data,
    output logic                           ar_valid,
    input  logic                           ar_ready,
    output reg_bus_pkg::ax_payload_t       ar_data,

    // Response buses from the register bank
    input  logic                           b_valid,
    output logic                           b_ready,
    input  reg_bus_pkg::b_payload_t        b_data,
    input  logic                           r_valid,
    output logic                           r_ready,
    input  reg_bus_pkg::r_payload_t        r_data
);

    logic req_en;

    logic aw_fifo_ready;
    logic w_fifo_ready;
    logic ar_fifo_ready;

    reg_bus_pkg::ax_payload_t aw_pkt;
    reg_bus_pkg::w_payload_t  w_pkt;
    reg_bus_pkg::ax_payload_t ar_pkt;
    reg_bus_pkg::b_payload_t  b_pkt;
    reg_bus_pkg::r_payload_t  r_pkt;

    // Request readiness stays off through reset and one cycle past it
    always_ff @(posedge aclk) begin
        if (reset) begin
            req_en <= 1'b0;
        end else begin
            req_en <= 1'b1;
        end
    end

    assign awready = req_en && aw_fifo_ready;
    assign wready  = req_en && w_fifo_ready;
    assign arready = req_en && ar_fifo_ready;

    // Pack request channels
    assign aw_pkt.prot = awprot;
    assign aw_pkt.addr = awaddr;
    assign w_pkt.data  = wdata;
    assign w_pkt.strb  = wstrb;
    assign ar_pkt.prot = arprot;
    assign ar_pkt.addr = araddr;

    bus_fifo #(.payload_t(reg_bus_pkg::ax_payload_t)) i_aw_fifo (
        .aclk      (aclk),
        .reset     (reset),
        .in_valid  (awvalid && req_en),
        .in_ready  (aw_fifo_ready),
        .in_data   (aw_pkt),
        .out_valid (aw_valid),
        .out_ready (aw_ready),
        .out_data  (aw_data)
    );

    bus_fifo #(.payload_t(reg_bus_pkg::w_payload_t)) i_w_fifo (
        .aclk      (aclk),
        .reset     (reset),
        .in_valid  (wvalid && req_en),
        .in_ready  (w_fifo_ready),
        .in_data   (w_pkt),
        .out_valid (w_valid),
        .out_ready (w_ready),
        .out_data  (w_data)
    );

    bus_fifo #(.payload_t(reg_bus_pkg::ax_payload_t)) i_ar_fifo (
        .aclk      (aclk),
        .reset     (reset),
        .in_valid  (arvalid && req_en),
        .in_ready  (ar_fifo_ready),
        .in_data   (ar_pkt),
        .out_valid (ar_valid),
        .out_ready (ar_ready),
        .out_data  (ar_data)
    );

    // Response channels are buffered, then unpacked to AXI
    bus_fifo #(.payload_t(reg_bus_pkg::b_payload_t)) i_b_fifo (
        .aclk      (aclk),
        .reset     (reset),
        .in_valid  (b_valid),
        .in_ready  (b_ready),
        .in_data   (b_data),
        .out_valid (bvalid),
        .out_ready (bready),
        .out_data  (b_pkt)
    );

    bus_fifo #(.payload_t(reg_bus_pkg::r_payload_t)) i_r_fifo (
        .aclk      (aclk),
        .reset     (reset),
        .in_valid  (r_valid),
        .in_ready  (r_ready),
        .in_data   (r_data),
        .out_valid (rvalid),
        .out_ready (rready),
        .out_data  (r_pkt)
    );

    assign bresp = b_pkt.resp;
    assign rdata = r_pkt.data;
    assign rresp = r_pkt.resp;

    // Controller must hold a stalled request steady
    a_aw_hold: assert property (
        @(posedge aclk) disable iff (reset)
        awvalid && !awready |=> awvalid && $stable(awaddr) && $stable(awprot)
    );

    a_w_hold: assert property (
        @(posedge aclk) disable iff (reset)
        wvalid && !wready |=> wvalid && $stable(wdata) && $stable(wstrb)
    );

    a_ar_hold: assert property (
        @(posedge aclk) disable iff (reset)
        arvalid && !arready |=> arvalid && $stable(araddr) && $stable(arprot)
    );

endmodule : axi4l_to_bus_adapter

`default_nettype wire

// File: logic/reg_bank.sv
// Register bank with 15 read/write words and a read-only ID word behind the internal buses
`timescale 1ns/1ps
`default_nettype none

module reg_bank (
    input  logic                     aclk,
    input  logic                     reset,

    // Request buses
    input  logic                     aw_valid,
    output logic                     aw_ready,
    input  reg_bus_pkg::ax_payload_t aw_data,
    input  logic                     w_valid,
    output logic                     w_ready,
    input  reg_bus_pkg::w_payload_t  w_data,
    input  logic                     ar_valid,
    output logic                     ar_ready,
    input  reg_bus_pkg::ax_payload_t ar_data,

    // Response buses
    output logic                     b_valid,
    input  logic                     b_ready,
    output reg_bus_pkg::b_payload_t  b_data,
    output logic                     r_valid,
    input  logic                     r_ready,
    output reg_bus_pkg::r_payload_t  r_data
);

    logic [axi4l_pkg::DATA_WID-1:0] regs [axi4l_pkg::ID_REG_INDEX];

    logic [axi4l_pkg::WORD_IDX_WID-1:0] wr_idx;
    logic [axi4l_pkg::WORD_IDX_WID-1:0] rd_idx;
    logic [axi4l_pkg::REG_SEL_WID-1:0]  wr_sel;
    logic [axi4l_pkg::REG_SEL_WID-1:0]  rd_sel;

    logic b_room;
    logic r_room;
    logic wr_take;
    logic rd_take;
    logic wr_in_map;
    logic rd_in_map;
    logic wr_is_id;
    logic rd_is_id;

    axi4l_pkg::resp_t               wr_resp;
    axi4l_pkg::resp_t               rd_resp;
    logic [axi4l_pkg::DATA_WID-1:0] rd_word;

    // Output stage has room when empty or draining this cycle
    assign b_room = !b_valid || b_ready;
    assign r_room = !r_valid || r_ready;

    // Address and data of a write are taken together
    assign aw_ready = w_valid && b_room;
    assign w_ready  = aw_valid && b_room;
    assign ar_ready = r_room;

    assign wr_take = aw_valid && w_valid && b_room;
    assign rd_take = ar_valid && r_room;

    // Word decode ignores the low two address bits
    assign wr_idx = aw_data.addr[axi4l_pkg::ADDR_WID-1:2];
    assign rd_idx = ar_data.addr[axi4l_pkg::ADDR_WID-1:2];
    assign wr_sel = wr_idx[axi4l_pkg::REG_SEL_WID-1:0];
    assign rd_sel = rd_idx[axi4l_pkg::REG_SEL_WID-1:0];

    assign wr_in_map = wr_idx < axi4l_pkg::WORD_IDX_WID'(axi4l_pkg::NUM_REGS);
    assign rd_in_map = rd_idx < axi4l_pkg::WORD_IDX_WID'(axi4l_pkg::NUM_REGS);
    assign wr_is_id  = wr_idx == axi4l_pkg::WORD_IDX_WID'(axi4l_pkg::ID_REG_INDEX);
    assign rd_is_id  = rd_idx == axi4l_pkg::WORD_IDX_WID'(axi4l_pkg::ID_REG_INDEX);

    always_comb begin
        if (!wr_in_map) begin
            wr_resp = axi4l_pkg::RESP_DECERR;
        end else if (wr_is_id) begin
            wr_resp = axi4l_pkg::RESP_SLVERR;
        end else begin
            wr_resp = axi4l_pkg::RESP_OKAY;
        end
    end

    always_comb begin
        if (!rd_in_map) begin
            rd_resp = axi4l_pkg::RESP_DECERR;
            rd_word = '0;
        end else if (rd_is_id) begin
            rd_resp = axi4l_pkg::RESP_OKAY;
            rd_word = axi4l_pkg::ID_VALUE;
        end else begin
            rd_resp = axi4l_pkg::RESP_OKAY;
            rd_word = regs[rd_sel];
        end
    end

    // Only strobed bytes of a writable word in the map change
    always_ff @(posedge aclk) begin
        if (reset) begin
            for (int i = 0; i < axi4l_pkg::ID_REG_INDEX; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_take && wr_resp == axi4l_pkg::RESP_OKAY) begin
            for (int b = 0; b < axi4l_pkg::STRB_WID; b++) begin
                if (w_data.strb[b]) begin
                    regs[wr_sel][b*8 +: 8] <= w_data.data[b*8 +: 8];
                end
            end
        end
    end

    // Response stages
    always_ff @(posedge aclk) begin
        if (reset) begin
            b_valid <= 1'b0;
            r_valid <= 1'b0;
        end else begin
            if (wr_take) begin
                b_valid <= 1'b1;
            end else if (b_ready) begin
                b_valid <= 1'b0;
            end
            if (rd_take) begin
                r_valid <= 1'b1;
            end else if (r_ready) begin
                r_valid <= 1'b0;
            end
        end
    end

    always_ff @(posedge aclk) begin
        if (wr_take) begin
            b_data.resp <= wr_resp;
        end
        if (rd_take) begin
            r_data.data <= rd_word;
            r_data.resp <= rd_resp;
        end
    end

    // A fresh response entry needs a request accepted one cycle earlier
    a_b_cause: assert property (
        @(posedge aclk) disable iff (reset)
        b_valid && !$past(b_valid && !b_ready) |-> $past(wr_take)
    );

    a_r_cause: assert property (
        @(posedge aclk) disable iff (reset)
        r_valid && !$past(r_valid && !r_ready) |-> $past(rd_take)
    );

endmodule : reg_bank

`default_nettype wire

// File: logic/axi4l_reg_subsys.sv
// AXI4-Lite register subsystem top level, adapter in front of the register bank
`timescale 1ns/1ps
`default_nettype none

module axi4l_reg_subsys (
    input  logic                           aclk,
    input  logic                           reset,

    // Write address
    input  logic                           awvalid,
    output logic                           awready,
    input  logic [axi4l_pkg::ADDR_WID-1:0] awaddr,
    input  logic [2:0]                     awprot,

    // Write data
    input  logic                           wvalid,
    output logic                           wready,
    input  logic [axi4l_pkg::DATA_WID-1:0] wdata,
    input  logic [axi4l_pkg::STRB_WID-1:0] wstrb,

    // Write response
    output logic                           bvalid,
    input  logic                           bready,
    output axi4l_pkg::resp_t               bresp,

    // Read address
    input  logic                           arvalid,
    output logic                           arready,
    input  logic [axi4l_pkg::ADDR_WID-1:0] araddr,
    input  logic [2:0]                     arprot,

    // Read data
    output logic                           rvalid,
    input  logic                           rready,
    output logic [axi4l_pkg::DATA_WID-1:0] rdata,
    output axi4l_pkg::resp_t               rresp
);

    // Internal buses between adapter and register bank
    logic                     aw_valid;
    logic                     aw_ready;
    reg_bus_pkg::ax_payload_t aw_data;
    logic                     w_valid;
    logic                     w_ready;
    reg_bus_pkg::w_payload_t  w_data;
    logic                     ar_valid;
    logic                     ar_ready;
    reg_bus_pkg::ax_payload_t ar_data;
    logic                     b_valid;
    logic                     b_ready;
    reg_bus_pkg::b_payload_t  b_data;
    logic                     r_valid;
    logic                     r_ready;
    reg_bus_pkg::r_payload_t  r_data;

    axi4l_to_bus_adapter i_axi4l_to_bus_adapter (
        .aclk     (aclk),
        .reset    (reset),
        .awvalid  (awvalid),
        .awready  (awready),
        .awaddr   (awaddr),
        .awprot   (awprot),
        .wvalid   (wvalid),
        .wready   (wready),
        .wdata    (wdata),
        .wstrb    (wstrb),
        .bvalid   (bvalid),
        .bready   (bready),
        .bresp    (bresp),
        .arvalid  (arvalid),
        .arready  (arready),
        .araddr   (araddr),
        .arprot   (arprot),
        .rvalid   (rvalid),
        .rready   (rready),
        .rdata    (rdata),
        .rresp    (rresp),
        .aw_valid (aw_valid),
        .aw_ready (aw_ready),
        .aw_data  (aw_data),
        .w_valid  (w_valid),
        .w_ready  (w_ready),
        .w_data   (w_data),
        .ar_valid (ar_valid),
        .ar_ready (ar_ready),
        .ar_data  (ar_data),
        .b_valid  (b_valid),
        .b_ready  (b_ready),
        .b_data   (b_data),
        .r_valid  (r_valid),
        .r_ready  (r_ready),
        .r_data   (r_data)
    );

    reg_bank i_reg_bank (
        .aclk     (aclk),
        .reset    (reset),
        .aw_valid (aw_valid),
        .aw_ready (aw_ready),
        .aw_data  (aw_data),
        .w_valid  (w_valid),
        .w_ready  (w_ready),
        .w_data   (w_data),
        .ar_valid (ar_valid),
        .ar_ready (ar_ready),
        .ar_data  (ar_data),
        .b_valid  (b_valid),
        .b_ready  (b_ready),
        .b_data   (b_data),
        .r_valid  (r_valid),
        .r_ready  (r_ready),
        .r_data   (r_data)
    );

endmodule : axi4l_reg_subsys

`default_nettype wire

// File: dv/tb_clk_gen.sv
// Testbench clock generator, free-running aclk with a 100 ns period
`timescale 1ns/1ps
`default_nettype none

module tb_clk_gen #(
    parameter int PERIOD_NS = 100
) (
    output logic aclk
);

    initial begin
        aclk = 1'b0;
        forever begin
            #(PERIOD_NS / 2) aclk = ~aclk;
        end
    end

endmodule : tb_clk_gen

`default_nettype wire

// File: dv/axi4l_reg_subsys_tb.sv
// Testbench for the AXI4-Lite register subsystem, checks responses against a register model
`timescale 1ns/1ps
`default_nettype none

module axi4l_reg_subsys_tb;

    localparam int DRIVE_DLY  = 10;
    // Roughly 130 transactions at up to 30 cycles each under stall plus margin
    localparam int MAX_CYCLES = 130 * 30 + 100;

    logic                           aclk;
    logic                           reset;
    logic                           awvalid;
    logic                           awready;
    logic [axi4l_pkg::ADDR_WID-1:0] awaddr;
    logic [2:0]                     awprot;
    logic                           wvalid;
    logic                           wready;
    logic [axi4l_pkg::DATA_WID-1:0] wdata;
    logic [axi4l_pkg::STRB_WID-1:0] wstrb;
    logic                           bvalid;
    logic                           bready;
    axi4l_pkg::resp_t               bresp;
    logic                           arvalid;
    logic                           arready;
    logic [axi4l_pkg::ADDR_WID-1:0] araddr;
    logic [2:0]                     arprot;
    logic                           rvalid;
    logic                           rready;
    logic [axi4l_pkg::DATA_WID-1:0] rdata;
    axi4l_pkg::resp_t               rresp;

    integer seed = 32'hd913;
    string  test_name = "reset";
    int     cycle_count = 0;
    int     err_value = 0;
    int     err_proto = 0;
    int     err_reset = 0;
    int     err_stall = 0;
    logic   reset_q = 1'b0;
    logic   stalling = 1'b0;
    logic   ready_fell = 1'b0;

    // Register model and expected response queues
    logic [axi4l_pkg::DATA_WID-1:0] model [axi4l_pkg::NUM_REGS];
    axi4l_pkg::resp_t               exp_b_q [$];
    logic [axi4l_pkg::DATA_WID-1:0] exp_rdata_q [$];
    axi4l_pkg::resp_t               exp_rresp_q [$];

    // Queue heads as static signals for the assertions
    logic                           b_head_valid = 1'b0;
    axi4l_pkg::resp_t               exp_bresp_head = axi4l_pkg::RESP_OKAY;
    logic                           r_head_valid = 1'b0;
    logic [axi4l_pkg::DATA_WID-1:0] exp_rdata_head = '0;
    axi4l_pkg::resp_t               exp_rresp_head = axi4l_pkg::RESP_OKAY;

    tb_clk_gen #(.PERIOD_NS(100)) i_tb_clk_gen (.aclk(aclk));

    axi4l_reg_subsys i_axi4l_reg_subsys (
        .aclk    (aclk),
        .reset   (reset),
        .awvalid (awvalid),
        .awready (awready),
        .awaddr  (awaddr),
        .awprot  (awprot),
        .wvalid  (wvalid),
        .wready  (wready),
        .wdata   (wdata),
        .wstrb   (wstrb),
        .bvalid  (bvalid),
        .bready  (bready),
        .bresp   (bresp),
        .arvalid (arvalid),
        .arready (arready),
        .araddr  (araddr),
        .arprot  (arprot),
        .rvalid  (rvalid),
        .rready  (rready),
        .rdata   (rdata),
        .rresp   (rresp)
    );

    task automatic refresh_heads();
        b_head_valid = (exp_b_q.size() != 0);
        if (b_head_valid) begin
            exp_bresp_head = exp_b_q[0];
        end
        r_head_valid = (exp_rdata_q.size() != 0);
        if (r_head_valid) begin
            exp_rdata_head = exp_rdata_q[0];
            exp_rresp_head = exp_rresp_q[0];
        end
    endtask

    // Registers 0 to 14 take strobed bytes and register 15 is read-only
    function automatic axi4l_pkg::resp_t model_write(
        input logic [axi4l_pkg::ADDR_WID-1:0] addr,
        input logic [axi4l_pkg::DATA_WID-1:0] data,
        input logic [axi4l_pkg::STRB_WID-1:0] strb
    );
        int idx;
        idx = addr[axi4l_pkg::ADDR_WID-1:2];
        if (idx >= axi4l_pkg::NUM_REGS) begin
            return axi4l_pkg::RESP_DECERR;
        end
        if (idx == axi4l_pkg::ID_REG_INDEX) begin
            return axi4l_pkg::RESP_SLVERR;
        end
        for (int b = 0; b < axi4l_pkg::STRB_WID; b++) begin
            if (strb[b]) begin
                model[idx][b*8 +: 8] = data[b*8 +: 8];
            end
        end
        return axi4l_pkg::RESP_OKAY;
    endfunction

    function automatic logic [axi4l_pkg::ADDR_WID-1:0] word_addr(input int idx);
        logic [axi4l_pkg::ADDR_WID-1:0] addr;
        addr = idx * 4;
        // Random low two bits that the decode must ignore
        addr[1:0] = $random(seed);
        return addr;
    endfunction

    task automatic idle_cycles(input int n);
        repeat (n) begin
            @(posedge aclk);
            #DRIVE_DLY;
        end
    endtask

    task automatic send_aw(input logic [axi4l_pkg::ADDR_WID-1:0] addr);
        awvalid = 1'b1;
        awaddr  = addr;
        awprot  = $random(seed);
        @(posedge aclk);
        while (!awready) begin
            @(posedge aclk);
        end
        #DRIVE_DLY;
        awvalid = 1'b0;
    endtask

    task automatic send_w(
        input logic [axi4l_pkg::DATA_WID-1:0] data,
        input logic [axi4l_pkg::STRB_WID-1:0] strb
    );
        wvalid = 1'b1;
        wdata  = data;
        wstrb  = strb;
        @(posedge aclk);
        while (!wready) begin
            @(posedge aclk);
        end
        #DRIVE_DLY;
        wvalid = 1'b0;
    endtask

    task automatic send_ar(input logic [axi4l_pkg::ADDR_WID-1:0] addr);
        arvalid = 1'b1;
        araddr  = addr;
        arprot  = $random(seed);
        @(posedge aclk);
        while (!arready) begin
            @(posedge aclk);
        end
        #DRIVE_DLY;
        arvalid = 1'b0;
    endtask

    // AW and W start with independent random gaps, so either may lead
    task automatic write_reg(
        input int                             idx,
        input logic [axi4l_pkg::DATA_WID-1:0] data,
        input logic [axi4l_pkg::STRB_WID-1:0] strb
    );
        logic [axi4l_pkg::ADDR_WID-1:0] addr;
        int                             aw_gap;
        int                             w_gap;
        addr   = word_addr(idx);
        aw_gap = $unsigned($random(seed)) % 3;
        w_gap  = $unsigned($random(seed)) % 3;
        exp_b_q.push_back(model_write(addr, data, strb));
        refresh_heads();
        fork
            begin
                idle_cycles(aw_gap);
                send_aw(addr);
            end
            begin
                idle_cycles(w_gap);
                send_w(data, strb);
            end
        join
    endtask

    task automatic read_reg(input int idx);
        logic [axi4l_pkg::DATA_WID-1:0] data;
        axi4l_pkg::resp_t               resp;
        if (idx >= axi4l_pkg::NUM_REGS) begin
            data = '0;
            resp = axi4l_pkg::RESP_DECERR;
        end else begin
            data = model[idx];
            resp = axi4l_pkg::RESP_OKAY;
        end
        exp_rdata_q.push_back(data);
        exp_rresp_q.push_back(resp);
        refresh_heads();
        idle_cycles($unsigned($random(seed)) % 2);
        send_ar(word_addr(idx));
    endtask

    task automatic drain_responses();
        do begin
            @(posedge aclk);
            #DRIVE_DLY;
        end while (exp_b_q.size() != 0 || exp_rdata_q.size() != 0);
    endtask

    // Random phases of 1 to 16 cycles with bready and rready low or high
    task automatic run_stalls();
        int bits;
        while (stalling) begin
            bits   = $random(seed);
            bready = bits[0];
            rready = bits[1];
            idle_cycles(bits[5:2] + 1);
        end
        bready = 1'b1;
        rready = 1'b1;
    endtask

    // Stream writes stay in 0 to 7 so reads of 8 to 14 remain stable
    task automatic write_stream(input int n);
        int r;
        int idx;
        for (int i = 0; i < n; i++) begin
            r = $unsigned($random(seed)) % 16;
            if (r == 14) begin
                idx = axi4l_pkg::ID_REG_INDEX;
            end else if (r == 15) begin
                idx = axi4l_pkg::NUM_REGS + $unsigned($random(seed)) % 256;
            end else begin
                idx = r % 8;
            end
            write_reg(idx, $random(seed), $random(seed));
        end
    endtask

    task automatic read_stream(input int n);
        int r;
        for (int i = 0; i < n; i++) begin
            r = $unsigned($random(seed)) % 10;
            if (r == 9) begin
                read_reg(axi4l_pkg::NUM_REGS + $unsigned($random(seed)) % 512);
            end else begin
                read_reg(8 + r % 8);
            end
        end
    endtask

    always @(posedge aclk) begin
        cycle_count <= cycle_count + 1;
        reset_q     <= reset;
        if (stalling && (!awready || !wready || !arready)) begin
            ready_fell <= 1'b1;
        end
    end

    // Retire expected entries on each response handshake
    always @(posedge aclk) begin
        if (!reset && bvalid && bready && exp_b_q.size() != 0) begin
            void'(exp_b_q.pop_front());
            refresh_heads();
        end
        if (!reset && rvalid && rready && exp_rdata_q.size() != 0) begin
            void'(exp_rdata_q.pop_front());
            void'(exp_rresp_q.pop_front());
            refresh_heads();
        end
    end

    a_reset_quiet: assert property (
        @(posedge aclk)
        reset_q |-> !awready && !wready && !arready && !bvalid && !rvalid
    ) else begin
        err_reset++;
        $display("Ready or response valid was high during reset or the cycle after it");
    end

    a_b_expected: assert property (
        @(posedge aclk) disable iff (reset)
        bvalid && bready |-> b_head_valid
    ) else begin
        err_proto++;
        $display("Write response arrived with no write outstanding in %s", test_name);
    end

    a_r_expected: assert property (
        @(posedge aclk) disable iff (reset)
        rvalid && rready |-> r_head_valid
    ) else begin
        err_proto++;
        $display("Read response arrived with no read outstanding in %s", test_name);
    end

    a_bresp: assert property (
        @(posedge aclk) disable iff (reset)
        bvalid && bready && b_head_valid |-> bresp == exp_bresp_head
    ) else begin
        err_value++;
        $display("** Error %s: bresp expected %0h, actual %0h",
                 test_name, $sampled(exp_bresp_head), $sampled(bresp));
    end

    a_rresp: assert property (
        @(posedge aclk) disable iff (reset)
        rvalid && rready && r_head_valid |-> rresp == exp_rresp_head
    ) else begin
        err_value++;
        $display("** Error %s: rresp expected %0h, actual %0h",
                 test_name, $sampled(exp_rresp_head), $sampled(rresp));
    end

    a_rdata: assert property (
        @(posedge aclk) disable iff (reset)
        rvalid && rready && r_head_valid |-> rdata == exp_rdata_head
    ) else begin
        err_value++;
        $display("** Error %s: rdata expected %h, actual %h",
                 test_name, $sampled(exp_rdata_head), $sampled(rdata));
    end

    initial begin
        while (cycle_count < MAX_CYCLES) begin
            @(posedge aclk);
        end
        $display("Run timed out after %0d cycles", MAX_CYCLES);
        $display("SOME TESTS FAILED");
        $finish;
    end

    initial begin
        reset   = 1'b1;
        awvalid = 1'b0;
        awaddr  = '0;
        awprot  = '0;
        wvalid  = 1'b0;
        wdata   = '0;
        wstrb   = '0;
        bready  = 1'b1;
        arvalid = 1'b0;
        araddr  = '0;
        arprot  = '0;
        rready  = 1'b1;
        for (int i = 0; i < axi4l_pkg::NUM_REGS; i++) begin
            model[i] = '0;
        end
        model[axi4l_pkg::ID_REG_INDEX] = axi4l_pkg::ID_VALUE;

        repeat (2) @(posedge aclk);
        #DRIVE_DLY;
        reset = 1'b0;
        idle_cycles(2);

        test_name = "full_strobe";
        for (int i = 0; i < axi4l_pkg::ID_REG_INDEX; i++) begin
            write_reg(i, $random(seed), 4'hf);
        end
        drain_responses();
        for (int i = 0; i < axi4l_pkg::ID_REG_INDEX; i++) begin
            read_reg(i);
        end
        drain_responses();

        test_name = "partial_strobe";
        for (int i = 0; i < 8; i++) begin
            write_reg($unsigned($random(seed)) % axi4l_pkg::ID_REG_INDEX,
                      $random(seed), $random(seed));
        end
        drain_responses();
        for (int i = 0; i < axi4l_pkg::ID_REG_INDEX; i++) begin
            read_reg(i);
        end
        drain_responses();

        test_name = "id_register";
        read_reg(axi4l_pkg::ID_REG_INDEX);
        write_reg(axi4l_pkg::ID_REG_INDEX, $random(seed), 4'hf);
        drain_responses();
        read_reg(axi4l_pkg::ID_REG_INDEX);
        drain_responses();

        // Indexes 16 and 31 alias register 0 and the ID word in the low bits
        test_name = "decode_error";
        write_reg(16, $random(seed), 4'hf);
        write_reg(31, $random(seed), 4'hf);
        write_reg(32 + $unsigned($random(seed)) % 992, $random(seed), 4'hf);
        drain_responses();
        read_reg(16);
        read_reg(31);
        read_reg(32 + $unsigned($random(seed)) % 992);
        read_reg(0);
        drain_responses();

        test_name = "stall_stream";
        stalling = 1'b1;
        fork
            run_stalls();
            begin
                fork
                    write_stream(30);
                    read_stream(30);
                join
                stalling = 1'b0;
            end
        join
        drain_responses();
        for (int i = 0; i < 8; i++) begin
            read_reg(i);
        end
        drain_responses();

        // Quiet cycles so a stray extra response still meets the checks
        idle_cycles(8);

        a_ready_fell: assert (ready_fell) else begin
            err_stall++;
            $display("Request readiness never fell while responses were stalled");
        end

        $display("Error counts: value %0d, protocol %0d, reset %0d, stall %0d",
                 err_value, err_proto, err_reset, err_stall);
        if (err_value + err_proto + err_reset + err_stall == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

endmodule : axi4l_reg_subsys_tb

`default_nettype wire

// File: files.f
logic/axi4l_pkg.sv
logic/reg_bus_pkg.sv
logic/bus_fifo.sv
logic/axi4l_to_bus_adapter.sv
logic/reg_bank.sv
logic/axi4l_reg_subsys.sv
dv/tb_clk_gen.sv
dv/axi4l_reg_subsys_tb.sv

// File: Bender.yml
package:
  name: axi4l_reg_subsys

sources:
  - logic/axi4l_pkg.sv
  - logic/reg_bus_pkg.sv
  - logic/bus_fifo.sv
  - logic/axi4l_to_bus_adapter.sv
  - logic/reg_bank.sv
  - logic/axi4l_reg_subsys.sv
  - target: simulation
    files:
      - dv/tb_clk_gen.sv
      - dv/axi4l_reg_subsys_tb.sv
